//--- soc_params.svh
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// ########################################
// bus widths
// ########################################
`define ADDR_W 32
`define DATA_W 64
`define STRB_W 8

// ########################################
// clint window and registers
// ########################################
`define CLINT_BASE 32'h0200_0000
`define CLINT_SIZE 32'h0001_0000
`define MTIMECMP_OFS 32'h0000_4000
`define MTIME_OFS 32'h0000_bff8

// clocks per mtime tick
`define MTIME_DIV 1

`endif

//--- bus_pkg.sv
`include "soc_params.svh"

package bus_pkg;

    // single access from the data port
    typedef struct packed {
        logic [`ADDR_W-1:0] addr;
        logic [`DATA_W-1:0] wdata;
        logic [`STRB_W-1:0] wstrb;
        logic               write;
    } data_req_t;

    typedef struct packed {
        logic [`DATA_W-1:0] rdata;
        logic               err;
    } bus_resp_t;

    // ########################################
    // single beat external bus channels
    // ########################################
    typedef struct packed {
        logic [`ADDR_W-1:0] addr;
    } axi_aw_t;

    typedef struct packed {
        logic [`ADDR_W-1:0] addr;
    } axi_ar_t;

    typedef struct packed {
        logic [`DATA_W-1:0] data;
        logic [`STRB_W-1:0] strb;
    } axi_w_t;

    typedef struct packed {
        logic [1:0] resp;
    } axi_b_t;

    typedef struct packed {
        logic [`DATA_W-1:0] data;
        logic [1:0]         resp;
    } axi_r_t;

endpackage

//--- ctrl_pkg.sv
package ctrl_pkg;

    // arbiter fsm
    typedef enum logic [2:0] {
        st_idle,
        st_fetch_ar,
        st_fetch_r,
        st_data_ar,
        st_data_r,
        st_data_aw,
        st_data_b,
        st_clint
    } arb_state_e;

    typedef enum logic [1:0] {
        op_fetch,
        op_load,
        op_store
    } access_op_e;

endpackage

//--- arbiter_ctrl.sv
module arbiter_ctrl import ctrl_pkg::*; (
    input  logic clock,
    input  logic reset,
    input  logic fetch_valid,
    input  logic data_valid,
    input  logic data_write,
    input  logic is_clint,
    input  logic aw_ready,
    input  logic w_ready,
    input  logic ar_ready,
    input  logic b_valid,
    input  logic r_valid,
    output logic rst_sync,
    output logic fetch_ready,
    output logic data_ready,
    output logic grant_fetch,
    output logic grant_data,
    output logic clint_sel,
    output logic rsp_fetch,
    output logic rsp_data,
    output logic fetch_rvalid,
    output logic data_rvalid,
    output logic aw_valid,
    output logic w_valid,
    output logic ar_valid,
    output logic b_ready,
    output logic r_ready
);

    logic       rst_meta;
    arb_state_e state;
    arb_state_e state_next;
    logic       aw_done;     // aw already transferred
    logic       w_done;
    logic       aw_ok;
    logic       w_ok;
    logic       clint_wait;  // second cycle of a clint access
    logic       rsp_fetch_q;
    logic       rsp_data_q;

    // async assert and release after two clocks
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            rst_meta <= 1'b1;
            rst_sync <= 1'b1;
        end else begin
            rst_meta <= 1'b0;
            rst_sync <= rst_meta;
        end
    end

    // ########################################
    // grant with the data port first
    // ########################################
    assign grant_data  = (state == st_idle) && data_valid;
    assign grant_fetch = (state == st_idle) && fetch_valid && !data_valid;
    assign data_ready  = grant_data;
    assign fetch_ready = grant_fetch;

    assign aw_valid  = (state == st_data_aw) && !aw_done;
    assign w_valid   = (state == st_data_aw) && !w_done;
    assign ar_valid  = (state == st_fetch_ar) || (state == st_data_ar);
    assign r_ready   = (state == st_fetch_r) || (state == st_data_r);
    assign b_ready   = (state == st_data_b);
    assign clint_sel = (state == st_clint) && !clint_wait;

    assign aw_ok = aw_done || aw_ready;
    assign w_ok  = w_done || w_ready;

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (data_valid) begin
                    if (is_clint)
                        state_next = st_clint;
                    else if (data_write)
                        state_next = st_data_aw;
                    else
                        state_next = st_data_ar;
                end else if (fetch_valid) begin
                    state_next = st_fetch_ar;
                end
            end
            st_fetch_ar: if (ar_ready) state_next = st_fetch_r;
            st_fetch_r:  if (r_valid) state_next = st_idle;
            st_data_ar:  if (ar_ready) state_next = st_data_r;
            st_data_r:   if (r_valid) state_next = st_idle;
            st_data_aw:  if (aw_ok && w_ok) state_next = st_data_b;
            st_data_b:   if (b_valid) state_next = st_idle;
            st_clint:    if (clint_wait) state_next = st_idle;
            default:     state_next = st_idle;
        endcase
    end

    always_ff @(posedge clock or posedge rst_sync) begin
        if (rst_sync) begin
            state       <= st_idle;
            aw_done     <= 1'b0;
            w_done      <= 1'b0;
            clint_wait  <= 1'b0;
            rsp_fetch_q <= 1'b0;
            rsp_data_q  <= 1'b0;
        end else begin
            state      <= state_next;
            clint_wait <= (state == st_clint) && !clint_wait;
            if ((state == st_data_aw) && !(aw_ok && w_ok)) begin
                aw_done <= aw_ok;
                w_done  <= w_ok;
            end else begin
                aw_done <= 1'b0;
                w_done  <= 1'b0;
            end
            rsp_fetch_q <= (state == st_fetch_r) && r_valid;
            rsp_data_q  <= ((state == st_data_r) && r_valid) ||
                           ((state == st_data_b) && b_valid) ||
                           ((state == st_clint) && clint_wait);
        end
    end

    // response pulse one cycle after the r/b transfer
    assign rsp_fetch    = rsp_fetch_q;
    assign rsp_data     = rsp_data_q;
    assign fetch_rvalid = rsp_fetch_q;
    assign data_rvalid  = rsp_data_q;

    a_one_grant: assert property (@(posedge clock) disable iff (rst_sync)
        !(grant_fetch && grant_data));
    a_aw_hold: assert property (@(posedge clock) disable iff (rst_sync)
        (aw_valid && !aw_ready) |=> aw_valid);
    a_ar_hold: assert property (@(posedge clock) disable iff (rst_sync)
        (ar_valid && !ar_ready) |=> ar_valid);
    a_idle_exit: assert property (@(posedge clock) disable iff (rst_sync)
        ((state == st_idle) && !grant_fetch && !grant_data) |=> (state == st_idle));

endmodule

//--- bus_route.sv
`include "soc_params.svh"

module bus_route import bus_pkg::*; import ctrl_pkg::*; (
    input  logic               clock,
    input  logic               rst_sync,
    input  logic [`ADDR_W-1:0] fetch_addr,
    input  data_req_t          data_req,
    input  logic               grant_fetch,
    input  logic               grant_data,
    input  logic               clint_sel,
    input  logic               rsp_fetch,
    input  logic               rsp_data,
    input  axi_b_t             b,
    input  axi_r_t             r,
    input  logic               b_valid,
    input  logic               r_valid,
    input  bus_resp_t          clint_resp,
    output logic               is_clint,
    output axi_aw_t            aw,
    output axi_w_t             w,
    output axi_ar_t            ar,
    output data_req_t          clint_req,
    output bus_resp_t          fetch_resp,
    output bus_resp_t          data_resp
);

    logic [`ADDR_W-1:0] addr_q;
    logic [`DATA_W-1:0] wdata_q;
    logic [`STRB_W-1:0] wstrb_q;
    logic [`ADDR_W-1:0] data_ofs;
    access_op_e         op_q;
    logic               clint_pend;  // clint answer due this cycle
    bus_resp_t          resp_q;

    // fetch never reaches the clint
    assign data_ofs = data_req.addr - `CLINT_BASE;
    assign is_clint = grant_data && (data_ofs < `CLINT_SIZE);

    // ########################################
    // request latch
    // ########################################
    always_ff @(posedge clock) begin
        if (grant_data) begin
            addr_q  <= data_req.addr;
            wdata_q <= data_req.wdata;
            wstrb_q <= data_req.wstrb;
        end else if (grant_fetch) begin
            addr_q <= fetch_addr;
        end
    end

    always_ff @(posedge clock or posedge rst_sync) begin
        if (rst_sync) begin
            op_q       <= op_fetch;
            clint_pend <= 1'b0;
        end else begin
            clint_pend <= clint_sel;
            if (grant_data)
                op_q <= data_req.write ? op_store : op_load;
            else if (grant_fetch)
                op_q <= op_fetch;
        end
    end

    assign aw        = '{addr: addr_q};
    assign ar        = '{addr: addr_q};
    assign w         = '{data: wdata_q, strb: wstrb_q};
    assign clint_req = '{addr: addr_q, wdata: wdata_q, wstrb: wstrb_q,
                         write: (op_q == op_store)};

    // ########################################
    // response capture
    // ########################################
    always_ff @(posedge clock) begin
        if (clint_pend) begin
            resp_q.rdata <= clint_resp.rdata;
            resp_q.err   <= clint_resp.err;
        end else if (r_valid) begin
            resp_q.rdata <= r.data;
            resp_q.err   <= (r.resp != 2'b00);
        end else if (b_valid) begin
            resp_q.rdata <= '0;  // stores return zero
            resp_q.err   <= (b.resp != 2'b00);
        end
    end

    assign fetch_resp = rsp_fetch ? resp_q : '0;
    assign data_resp  = rsp_data ? resp_q : '0;

endmodule

//--- clint_timer.sv
`include "soc_params.svh"

module clint_timer import bus_pkg::*; (
    input  logic      clock,
    input  logic      rst_sync,
    input  logic      clint_sel,
    input  data_req_t clint_req,
    output bus_resp_t clint_resp,
    output logic      timer_irq
);

    localparam int DIV_W = $clog2(`MTIME_DIV) + 1;

    logic [DIV_W-1:0]   presc;
    logic               tick;
    logic [`DATA_W-1:0] mtime;
    logic [`DATA_W-1:0] mtimecmp;
    logic [`ADDR_W-1:0] ofs;
    logic               hit_cmp;
    logic               hit_time;
    logic               cmp_wr;
    logic               time_wr;

    // byte lanes of new_val replace old_val where strb is set
    function automatic logic [`DATA_W-1:0] merge(
        input logic [`DATA_W-1:0] old_val,
        input logic [`DATA_W-1:0] new_val,
        input logic [`STRB_W-1:0] strb
    );
        logic [`DATA_W-1:0] res;
        res = old_val;
        for (int i = 0; i < `STRB_W; i++) begin
            if (strb[i])
                res[i*8 +: 8] = new_val[i*8 +: 8];
        end
        return res;
    endfunction

    assign ofs      = clint_req.addr - `CLINT_BASE;
    assign hit_cmp  = (ofs == `MTIMECMP_OFS);
    assign hit_time = (ofs == `MTIME_OFS);
    assign cmp_wr   = clint_sel && clint_req.write && hit_cmp;
    assign time_wr  = clint_sel && clint_req.write && hit_time;
    assign tick     = (presc == DIV_W'(`MTIME_DIV - 1));

    // ########################################
    // timer registers
    // ########################################
    always_ff @(posedge clock or posedge rst_sync) begin
        if (rst_sync) begin
            presc    <= '0;
            mtime    <= '0;
            mtimecmp <= '1;  // no irq out of reset
        end else begin
            presc <= tick ? '0 : presc + 1'b1;
            if (time_wr)
                mtime <= merge(mtime, clint_req.wdata, clint_req.wstrb);
            else if (tick)
                mtime <= mtime + 1'b1;
            if (cmp_wr)
                mtimecmp <= merge(mtimecmp, clint_req.wdata, clint_req.wstrb);
        end
    end

    // answer one cycle after select
    always_ff @(posedge clock) begin
        if (clint_sel) begin
            clint_resp.err <= !(hit_cmp || hit_time);
            if (clint_req.write)
                clint_resp.rdata <= '0;
            else if (hit_cmp)
                clint_resp.rdata <= mtimecmp;
            else if (hit_time)
                clint_resp.rdata <= mtime;
            else
                clint_resp.rdata <= '0;
        end
    end

    assign timer_irq = (mtime >= mtimecmp);

    a_mtime_mono: assert property (@(posedge clock) disable iff (rst_sync)
        !time_wr |=> (mtime >= $past(mtime)));

endmodule

//--- mem_subsys_top.sv
`include "soc_params.svh"

module mem_subsys_top import bus_pkg::*; (
    input  logic               clock,
    input  logic               reset,
    // fetch port
    input  logic               fetch_valid,
    input  logic [`ADDR_W-1:0] fetch_addr,
    output logic               fetch_ready,
    output logic               fetch_rvalid,
    output bus_resp_t          fetch_resp,
    // data port
    input  logic               data_valid,
    input  data_req_t          data_req,
    output logic               data_ready,
    output logic               data_rvalid,
    output bus_resp_t          data_resp,
    // external bus
    output logic               aw_valid,
    input  logic               aw_ready,
    output axi_aw_t            aw,
    output logic               w_valid,
    input  logic               w_ready,
    output axi_w_t             w,
    input  logic               b_valid,
    output logic               b_ready,
    input  axi_b_t             b,
    output logic               ar_valid,
    input  logic               ar_ready,
    output axi_ar_t            ar,
    input  logic               r_valid,
    output logic               r_ready,
    input  axi_r_t             r,
    output logic               timer_irq
);

    logic      rst_sync;
    logic      grant_fetch;
    logic      grant_data;
    logic      clint_sel;
    logic      rsp_fetch;
    logic      rsp_data;
    logic      is_clint;
    data_req_t clint_req;
    bus_resp_t clint_resp;

    arbiter_ctrl u_arbiter_ctrl (
        .clock, .reset, .fetch_valid, .data_valid,
        .data_write (data_req.write),
        .is_clint, .aw_ready, .w_ready, .ar_ready, .b_valid, .r_valid,
        .rst_sync, .fetch_ready, .data_ready, .grant_fetch, .grant_data,
        .clint_sel, .rsp_fetch, .rsp_data, .fetch_rvalid, .data_rvalid,
        .aw_valid, .w_valid, .ar_valid, .b_ready, .r_ready
    );

    bus_route u_bus_route (
        .clock, .rst_sync, .fetch_addr, .data_req, .grant_fetch, .grant_data,
        .clint_sel, .rsp_fetch, .rsp_data, .b, .r, .b_valid, .r_valid,
        .clint_resp, .is_clint, .aw, .w, .ar, .clint_req, .fetch_resp, .data_resp
    );

    clint_timer u_clint_timer (
        .clock, .rst_sync, .clint_sel, .clint_req, .clint_resp, .timer_irq
    );

endmodule

//--- tb_bus_model.sv
`include "soc_params.svh"

module tb_bus_model import bus_pkg::*; (
    input  logic    clock,
    input  logic    reset,
    input  logic    aw_valid,
    output logic    aw_ready,
    input  axi_aw_t aw,
    input  logic    w_valid,
    output logic    w_ready,
    input  axi_w_t  w,
    output logic    b_valid,
    input  logic    b_ready,
    output axi_b_t  b,
    input  logic    ar_valid,
    output logic    ar_ready,
    input  axi_ar_t ar,
    output logic    r_valid,
    input  logic    r_ready,
    output axi_r_t  r
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [`DATA_W-1:0] mem [0:255];  // word addressed
    logic [`ADDR_W-1:0] rd_addr;
    logic [`ADDR_W-1:0] wr_addr;
    axi_w_t             wr_beat;
    logic               rd_pend;
    logic               wr_pend;
    logic               aw_got;
    logic               w_got;
    int                 ar_wait;
    int                 aw_wait;
    int                 w_wait;
    int                 rsp_wait;
    logic               ar_rdy_n;
    logic               aw_rdy_n;
    logic               w_rdy_n;
    logic               r_vld_n;
    logic               b_vld_n;
    axi_r_t             r_n;
    axi_b_t             b_n;

    function automatic int random_delay();
        return $urandom_range(3, 0);
    endfunction

    initial begin
        for (int i = 0; i < 256; i++)
            mem[i] = {32'(i) ^ 32'h5a5a_0f0f, 32'(i) * 32'h0101_0101};
        ar_ready = 1'b0;
        aw_ready = 1'b0;
        w_ready  = 1'b0;
        r_valid  = 1'b0;
        b_valid  = 1'b0;
        r        = '0;
        b        = '0;
    end

    // sample at the edge and drive 10 ns later
    always @(posedge clock) begin
        ar_rdy_n = ar_ready;
        aw_rdy_n = aw_ready;
        w_rdy_n  = w_ready;
        r_vld_n  = r_valid;
        b_vld_n  = b_valid;
        r_n      = r;
        b_n      = b;
        if (reset) begin
            ar_rdy_n = 1'b0;
            aw_rdy_n = 1'b0;
            w_rdy_n  = 1'b0;
            r_vld_n  = 1'b0;
            b_vld_n  = 1'b0;
            rd_pend  = 1'b0;
            wr_pend  = 1'b0;
            aw_got   = 1'b0;
            w_got    = 1'b0;
            ar_wait  = random_delay();
            aw_wait  = random_delay();
            w_wait   = random_delay();
            rsp_wait = random_delay();
        end else begin
            // ########################################
            // address and write data channels
            // ########################################
            if (ar_valid && ar_ready) begin
                ar_rdy_n = 1'b0;
                rd_addr  = ar.addr;
                rd_pend  = 1'b1;
                ar_wait  = random_delay();
                rsp_wait = random_delay();
            end else if (ar_valid) begin
                if (ar_wait == 0) ar_rdy_n = 1'b1;
                else ar_wait--;
            end
            if (aw_valid && aw_ready) begin
                aw_rdy_n = 1'b0;
                wr_addr  = aw.addr;
                aw_got   = 1'b1;
                aw_wait  = random_delay();
            end else if (aw_valid) begin
                if (aw_wait == 0) aw_rdy_n = 1'b1;
                else aw_wait--;
            end
            if (w_valid && w_ready) begin
                w_rdy_n = 1'b0;
                wr_beat = w;
                w_got   = 1'b1;
                w_wait  = random_delay();
            end else if (w_valid) begin
                if (w_wait == 0) w_rdy_n = 1'b1;
                else w_wait--;
            end
            if (aw_got && w_got) begin  // both halves of the write are in
                if (!wr_addr[31]) begin
                    for (int i = 0; i < `STRB_W; i++) begin
                        if (wr_beat.strb[i])
                            mem[wr_addr[10:3]][i*8 +: 8] = wr_beat.data[i*8 +: 8];
                    end
                end
                aw_got   = 1'b0;
                w_got    = 1'b0;
                wr_pend  = 1'b1;
                rsp_wait = random_delay();
            end
            // ########################################
            // response channels
            // ########################################
            if (r_valid && r_ready) begin
                r_vld_n = 1'b0;
            end else if (rd_pend) begin
                if (rsp_wait == 0) begin
                    r_vld_n  = 1'b1;
                    rd_pend  = 1'b0;
                    r_n.data = rd_addr[31] ? '0 : mem[rd_addr[10:3]];
                    r_n.resp = rd_addr[31] ? 2'd2 : 2'd0;  // error region
                end else begin
                    rsp_wait--;
                end
            end
            if (b_valid && b_ready) begin
                b_vld_n = 1'b0;
            end else if (wr_pend) begin
                if (rsp_wait == 0) begin
                    b_vld_n  = 1'b1;
                    wr_pend  = 1'b0;
                    b_n.resp = wr_addr[31] ? 2'd2 : 2'd0;
                end else begin
                    rsp_wait--;
                end
            end
        end
        #10;
        ar_ready = ar_rdy_n;
        aw_ready = aw_rdy_n;
        w_ready  = w_rdy_n;
        r_valid  = r_vld_n;
        b_valid  = b_vld_n;
        r        = r_n;
        b        = b_n;
    end

endmodule

//--- tb_mem_subsys.sv
`include "soc_params.svh"

module tb_mem_subsys import bus_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] CMP_ADDR  = `CLINT_BASE + `MTIMECMP_OFS;
    localparam logic [31:0] TIME_ADDR = `CLINT_BASE + `MTIME_OFS;

    logic               clock;
    logic               reset;
    logic               fetch_valid;
    logic [`ADDR_W-1:0] fetch_addr;
    logic               fetch_ready;
    logic               fetch_rvalid;
    bus_resp_t          fetch_resp;
    logic               data_valid;
    data_req_t          data_req;
    logic               data_ready;
    logic               data_rvalid;
    bus_resp_t          data_resp;
    logic               aw_valid;
    logic               aw_ready;
    axi_aw_t            aw;
    logic               w_valid;
    logic               w_ready;
    axi_w_t             w;
    logic               b_valid;
    logic               b_ready;
    axi_b_t             b;
    logic               ar_valid;
    logic               ar_ready;
    axi_ar_t            ar;
    logic               r_valid;
    logic               r_ready;
    axi_r_t             r;
    logic               timer_irq;
    int                 cycles = 0;
    int                 rel_cycle = 0;  // mtime equals cycles minus this
    int                 n_tests = 0;
    int                 n_checks = 0;
    int                 n_errors = 0;
    logic [63:0]        stored_word;

    mem_subsys_top u_dut (.*);
    tb_bus_model u_mem (.*);

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    always @(posedge clock) cycles++;

    // ########################################
    // helpers
    // ########################################
    task automatic timeout_abort(input string what);
        $display("timeout: no %s within 200 cycles", what);
        $display("Testbench failed");
        $finish;
    endtask

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] got);
        n_checks++;
        assert (got === exp) else begin
            $display("ERROR %s: expected %h, actual %h", name, exp, got);
            n_errors++;
        end
    endtask

    task automatic check_true(input string name, input logic cond, input string what);
        n_checks++;
        assert (cond) else begin
            $display("%s: %s", name, what);
            n_errors++;
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        n_tests++;
        $display("%s %s", name, (n_errors == errors_before) ? "ok" : "FAILED");
    endtask

    function automatic logic [63:0] strobe_bytes(input logic [63:0] old_w,
                                                 input logic [63:0] new_w,
                                                 input logic [7:0]  strb);
        logic [63:0] res;
        res = old_w;
        for (int i = 0; i < 8; i++) begin
            if (strb[i]) res[i*8 +: 8] = new_w[i*8 +: 8];
        end
        return res;
    endfunction

    task automatic fetch_access(input logic [31:0] addr, output bus_resp_t resp);
        int n;
        @(posedge clock);
        #10;
        fetch_valid = 1'b1;
        fetch_addr  = addr;
        n = 0;
        @(negedge clock);
        while (!fetch_ready && n < 200) begin
            @(negedge clock);
            n++;
        end
        if (!fetch_ready) timeout_abort("fetch_ready");
        @(posedge clock);
        #10;
        fetch_valid = 1'b0;
        n = 0;
        @(negedge clock);
        while (!fetch_rvalid && n < 200) begin
            @(negedge clock);
            n++;
        end
        if (!fetch_rvalid) timeout_abort("fetch_rvalid");
        resp = fetch_resp;
    endtask

    // lat counts edges from the accepting edge to the rvalid cycle
    task automatic data_access(input data_req_t req, output bus_resp_t resp,
                               output int lat);
        int n;
        @(posedge clock);
        #10;
        data_valid = 1'b1;
        data_req   = req;
        n = 0;
        @(negedge clock);
        while (!data_ready && n < 200) begin
            @(negedge clock);
            n++;
        end
        if (!data_ready) timeout_abort("data_ready");
        @(posedge clock);
        #10;
        data_valid = 1'b0;
        lat = 0;
        @(negedge clock);
        while (!data_rvalid && lat < 200) begin
            @(posedge clock);
            lat++;
            @(negedge clock);
        end
        if (!data_rvalid) timeout_abort("data_rvalid");
        resp = data_resp;
    endtask

    // ########################################
    // directed tests
    // ########################################
    task automatic test_fetch_read();
        bus_resp_t resp;
        int        e0;
        int        idx;
        e0 = n_errors;
        for (int k = 0; k < 3; k++) begin
            idx = 'h25 + k * 'h31;
            fetch_access(32'(idx * 8), resp);
            check_value("fetch_read data", u_mem.mem[idx], resp.rdata);
            check_value("fetch_read err", 64'd0, 64'(resp.err));
        end
        finish_test("fetch_read", e0);
    endtask

    task automatic test_store_load();
        bus_resp_t   resp;
        int          lat;
        int          e0;
        logic [63:0] old_w;
        e0    = n_errors;
        old_w = u_mem.mem['h68];
        stored_word = strobe_bytes(old_w, 64'h1122_3344_5566_7788, 8'b1010_0101);
        data_access(data_req_t'{addr: 32'h340, wdata: 64'h1122_3344_5566_7788,
                                wstrb: 8'b1010_0101, write: 1'b1}, resp, lat);
        check_value("store_load store err", 64'd0, 64'(resp.err));
        check_value("store_load store rdata", 64'd0, resp.rdata);
        data_access(data_req_t'{addr: 32'h340, wdata: '0, wstrb: '0, write: 1'b0},
                    resp, lat);
        check_value("store_load load data", stored_word, resp.rdata);
        check_value("store_load load err", 64'd0, 64'(resp.err));
        finish_test("store_load", e0);
    endtask

    task automatic test_simultaneous();
        bus_resp_t f_resp;
        bus_resp_t d_resp;
        logic      got_f;
        logic      got_d;
        logic      drop_f;
        logic      drop_d;
        logic      d_first;
        int        n;
        int        e0;
        e0      = n_errors;
        got_f   = 1'b0;
        got_d   = 1'b0;
        drop_f  = 1'b0;
        drop_d  = 1'b0;
        d_first = 1'b0;
        @(posedge clock);
        #10;
        fetch_valid = 1'b1;
        fetch_addr  = 32'h80;
        data_valid  = 1'b1;
        data_req    = data_req_t'{addr: 32'h100, wdata: '0, wstrb: '0, write: 1'b0};
        @(negedge clock);
        check_true("simultaneous", data_ready && !fetch_ready,
                   "data_ready did not pulse ahead of fetch_ready");
        n = 0;
        while (!(got_f && got_d) && n < 200) begin
            if (data_ready) drop_d = 1'b1;
            if (fetch_ready) drop_f = 1'b1;
            if (data_rvalid) begin
                got_d   = 1'b1;
                d_resp  = data_resp;
                d_first = !got_f;
            end
            if (fetch_rvalid) begin
                got_f  = 1'b1;
                f_resp = fetch_resp;
            end
            @(posedge clock);
            #10;
            if (drop_d) data_valid = 1'b0;
            if (drop_f) fetch_valid = 1'b0;
            @(negedge clock);
            n++;
        end
        if (!(got_f && got_d)) timeout_abort("responses to both requests");
        check_true("simultaneous", d_first, "fetch_rvalid arrived before data_rvalid");
        check_value("simultaneous data", u_mem.mem['h20], d_resp.rdata);
        check_value("simultaneous fetch", u_mem.mem['h10], f_resp.rdata);
        finish_test("simultaneous", e0);
    endtask

    task automatic test_clint();
        bus_resp_t   resp;
        int          lat;
        int          e0;
        int          issue;
        int          done;
        int          n;
        logic [63:0] now;
        e0 = n_errors;
        data_access(data_req_t'{addr: CMP_ADDR, wdata: 64'h0000_0012_3456_789a,
                                wstrb: 8'hff, write: 1'b1}, resp, lat);
        check_value("clint store latency", 64'd2, 64'(lat));
        check_value("clint store rdata", 64'd0, resp.rdata);
        data_access(data_req_t'{addr: CMP_ADDR, wdata: '0, wstrb: '0, write: 1'b0},
                    resp, lat);
        check_value("clint mtimecmp", 64'h0000_0012_3456_789a, resp.rdata);
        check_value("clint load latency", 64'd2, 64'(lat));
        issue = cycles - rel_cycle;
        data_access(data_req_t'{addr: TIME_ADDR, wdata: '0, wstrb: '0, write: 1'b0},
                    resp, lat);
        done = cycles - rel_cycle;
        now  = resp.rdata;
        check_true("clint mtime", (now >= 64'(issue)) && (now <= 64'(done)),
                   "mtime outside the cycle window of the access");
        data_access(data_req_t'{addr: CMP_ADDR, wdata: now + 64'd20, wstrb: 8'hff,
                                write: 1'b1}, resp, lat);
        check_true("clint irq", !timer_irq, "timer_irq high before mtime reached mtimecmp");
        n = 0;
        while (!timer_irq && n < 25) begin
            @(negedge clock);
            n++;
        end
        check_true("clint irq", timer_irq, "timer_irq did not rise within 25 cycles");
        finish_test("clint", e0);
    endtask

    task automatic test_errors();
        bus_resp_t resp;
        int        lat;
        int        e0;
        e0 = n_errors;
        data_access(data_req_t'{addr: 32'h8000_0040, wdata: '0, wstrb: '0, write: 1'b0},
                    resp, lat);
        check_value("errors bus load", 64'd1, 64'(resp.err));
        data_access(data_req_t'{addr: 32'h8000_0080, wdata: '1, wstrb: 8'hff,
                                write: 1'b1}, resp, lat);
        check_value("errors bus store", 64'd1, 64'(resp.err));
        data_access(data_req_t'{addr: `CLINT_BASE + 32'h100, wdata: '0, wstrb: '0,
                                write: 1'b0}, resp, lat);
        check_value("errors clint load", 64'd1, 64'(resp.err));
        data_access(data_req_t'{addr: `CLINT_BASE + 32'h200, wdata: '1, wstrb: 8'hff,
                                write: 1'b1}, resp, lat);
        check_value("errors clint store", 64'd1, 64'(resp.err));
        // normal traffic afterwards
        data_access(data_req_t'{addr: 32'h340, wdata: '0, wstrb: '0, write: 1'b0},
                    resp, lat);
        check_value("errors later load", stored_word, resp.rdata);
        check_value("errors later load err", 64'd0, 64'(resp.err));
        fetch_access(32'h128, resp);
        check_value("errors later fetch", u_mem.mem['h25], resp.rdata);
        finish_test("errors", e0);
    endtask

    initial begin
        void'($urandom(32'h545c_a26c));
        reset       = 1'b1;
        fetch_valid = 1'b0;
        fetch_addr  = '0;
        data_valid  = 1'b0;
        data_req    = '0;
        stored_word = '0;
        repeat (8) @(posedge clock);
        #10;
        reset     = 1'b0;
        rel_cycle = cycles + 2;  // synchroniser needs two edges
        repeat (3) @(posedge clock);
        test_fetch_read();
        test_store_load();
        test_simultaneous();
        test_clint();
        test_errors();
        $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
        if (n_errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

//--- sim.f
+incdir+.
bus_pkg.sv
ctrl_pkg.sv
arbiter_ctrl.sv
bus_route.sv
clint_timer.sv
mem_subsys_top.sv
tb_bus_model.sv
tb_mem_subsys.sv

//--- Bender.yml
package:
  name: mem_subsys

export_include_dirs:
  - .

sources:
  - files:
      - bus_pkg.sv
      - ctrl_pkg.sv
      - arbiter_ctrl.sv
      - bus_route.sv
      - clint_timer.sv
      - mem_subsys_top.sv
  - target: test
    files:
      - tb_bus_model.sv
      - tb_mem_subsys.sv
